/* design/core_pkg.sv */
// Shared types for the multicycle core; covers RV32I OP and OP-IMM only, all other opcodes are illegal
`default_nettype none

package core_pkg;

    ////////////////////
    // Major opcodes
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;

    ////////////////////
    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    ////////////////////
    // Instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    // One word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

    ////////////////////
    // Inter-block bundles
    typedef struct packed {
        alu_op_t     alu_op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        use_imm;
        logic [31:0] imm;
        logic        illegal;
    } decoded_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic [31:0] a;
        logic [31:0] b;
    } alu_inputs_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] value;
    } wb_t;

    // One record per retired instruction
    typedef struct packed {
        logic        retired;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [31:0] value;
    } trace_t;

endpackage

`default_nettype wire

/* design/pc_counter.sv */
// Program counter; word aligned only, IMEM_ADDR_W must not exceed 30, no branch or jump target load
`default_nettype none
`timescale 1ns/1ps

module pc_counter #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
    parameter int          IMEM_ADDR_W  = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    output logic [31:0]            pc,
    output logic [IMEM_ADDR_W-1:0] imem_addr
);

    ////////////////////
    // PC register

    // Sequential flow only
    // Advance comes once per retired instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else if (advance) begin
            pc <= pc + 32'd4;
        end
    end

    ////////////////////
    // Memory word address

    // Byte offset dropped
    // Upper pc bits beyond the memory are ignored
    assign imem_addr = pc[IMEM_ADDR_W+1:2];

endmodule

`default_nettype wire

/* design/issue_control.sv */
// Phase sequencer; one instruction in flight, four cycles each, HALT is left only through reset
`default_nettype none
`timescale 1ns/1ps

module issue_control (
    input  logic clk,
    input  logic rst,
    input  logic illegal,
    output logic imem_en,
    output logic capture,
    output logic exec_en,
    output logic retire,
    output logic halted
);

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        RETIRE,
        HALT
    } state_t;

    state_t state;
    state_t state_next;

    ////////////////////
    // Next state

    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                state_next = DECODE;
            end
            DECODE: begin
                // Bad word parks the core here
                if (illegal) begin
                    state_next = HALT;
                end else begin
                    state_next = EXECUTE;
                end
            end
            EXECUTE: begin
                state_next = RETIRE;
            end
            RETIRE: begin
                state_next = FETCH;
            end
            HALT: begin
                state_next = HALT;
            end
            default: begin
                state_next = HALT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // Phase strobes

    // Each lasts exactly one cycle per instruction
    assign imem_en = (state == FETCH);
    assign capture = (state == DECODE);
    assign exec_en = (state == EXECUTE);
    assign retire  = (state == RETIRE);
    // Sticky until reset
    assign halted  = (state == HALT);

endmodule

`default_nettype wire

/* design/decode.sv */
// Decoder for OP and OP-IMM; decodes the live memory word during capture, the held word otherwise
`default_nettype none
`timescale 1ns/1ps

module decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              capture,
    input  logic [31:0]       imem_data,
    output core_pkg::instr_t  instr,
    output core_pkg::decoded_t dec
);

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    localparam logic [6:0]  F7_ALT   = 7'b0100000;

    core_pkg::instr_t view;
    logic             is_op;
    logic             is_op_imm;
    logic [6:0]       f7;
    logic             f7_checked;
    logic             use_alt;

    ////////////////////
    // Instruction register
    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= NOP_WORD;
        end else if (capture) begin
            instr <= imem_data;
        end
    end

    // Live word in DECODE so the illegal flag is ready that cycle
    assign view = capture ? core_pkg::instr_t'(imem_data) : instr;

    assign is_op     = (view.r.opcode == core_pkg::OPC_OP);
    assign is_op_imm = (view.i.opcode == core_pkg::OPC_OP_IMM);

    // funct7 and imm12[11:5] share bits 31:25
    assign f7 = view.r.funct7;

    // Only register ops and shifts constrain the upper bits
    assign f7_checked = is_op || (view.i.funct3 == 3'b001) || (view.i.funct3 == 3'b101);
    // sub (register form only) and sra/srai
    assign use_alt = (f7 == F7_ALT) &&
                     ((view.r.funct3 == 3'b101) || (is_op && view.r.funct3 == 3'b000));

    ////////////////////
    // Field decode
    always_comb begin
        dec         = '0;
        dec.rs1     = view.r.rs1;
        dec.rd      = view.r.rd;
        // Unused rs2 field in I-type reads x0
        dec.rs2     = is_op ? view.r.rs2 : 5'd0;
        dec.use_imm = is_op_imm;
        dec.imm     = {{20{view.i.imm12[11]}}, view.i.imm12};

        case (view.r.funct3)
            3'b000: dec.alu_op = use_alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001: dec.alu_op = core_pkg::ALU_SLL;
            3'b010: dec.alu_op = core_pkg::ALU_SLT;
            3'b011: dec.alu_op = core_pkg::ALU_SLTU;
            3'b100: dec.alu_op = core_pkg::ALU_XOR;
            3'b101: dec.alu_op = use_alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110: dec.alu_op = core_pkg::ALU_OR;
            default: dec.alu_op = core_pkg::ALU_AND;
        endcase

        // Unknown opcode, or upper bits neither zero nor a valid alternate
        dec.illegal = !(is_op || is_op_imm) ||
                      (f7_checked && !(f7 == 7'd0 || use_alt));
    end

endmodule

`default_nettype wire

/* design/register_file.sv */
// 32 x 32 register file; reads are combinational, one write per cycle, x0 is never written
`default_nettype none
`timescale 1ns/1ps

module register_file (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  core_pkg::wb_t    wb,
    output logic [31:0]      rs1_data,
    output logic [31:0]      rs2_data
);

    logic [31:0] regs [32];

    ////////////////////
    // Write port

    // Reset clears the whole file
    // Writes to x0 dropped so it stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb.we && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.value;
        end
    end

    ////////////////////
    // Read ports

    // No bypass needed, only one instruction in flight
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

/* design/alu_unit.sv */
// Single-cycle ALU with registered result; shift amount taken from the low 5 bits of operand b
`default_nettype none
`timescale 1ns/1ps

module alu_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  exec_en,
    input  core_pkg::alu_inputs_t alu_in,
    output logic [31:0]           result
);

    logic [31:0] result_next;
    logic [4:0]  shamt;

    assign shamt = alu_in.b[4:0];

    ////////////////////
    // Operation select
    always_comb begin
        case (alu_in.alu_op)
            core_pkg::ALU_ADD:  result_next = alu_in.a + alu_in.b;
            core_pkg::ALU_SUB:  result_next = alu_in.a - alu_in.b;
            core_pkg::ALU_SLL:  result_next = alu_in.a << shamt;
            // Signed compare
            core_pkg::ALU_SLT:  result_next = {31'd0, $signed(alu_in.a) < $signed(alu_in.b)};
            // Unsigned compare
            core_pkg::ALU_SLTU: result_next = {31'd0, alu_in.a < alu_in.b};
            core_pkg::ALU_XOR:  result_next = alu_in.a ^ alu_in.b;
            core_pkg::ALU_SRL:  result_next = alu_in.a >> shamt;
            // Sign bit fills from the left
            core_pkg::ALU_SRA:  result_next = $unsigned($signed(alu_in.a) >>> shamt);
            core_pkg::ALU_OR:   result_next = alu_in.a | alu_in.b;
            core_pkg::ALU_AND:  result_next = alu_in.a & alu_in.b;
            default:            result_next = 32'd0;
        endcase
    end

    ////////////////////
    // Result register

    // Held through RETIRE for writeback and trace
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= 32'd0;
        end else if (exec_en) begin
            result <= result_next;
        end
    end

endmodule

`default_nettype wire

/* design/tiny_core.sv */
// Multicycle RV32I OP/OP-IMM core; instruction memory must return data exactly one cycle after imem_en
`default_nettype none
`timescale 1ns/1ps

module tiny_core #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
    parameter int          IMEM_ADDR_W  = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   imem_en,
    output logic [IMEM_ADDR_W-1:0] imem_addr,
    input  logic [31:0]            imem_data,
    output core_pkg::trace_t       tr,
    output logic                   halted
);

    logic [31:0]           pc;
    logic                  capture;
    logic                  exec_en;
    logic                  retire;
    core_pkg::instr_t      instr;
    core_pkg::decoded_t    dec;
    logic [31:0]           rs1_data;
    logic [31:0]           rs2_data;
    core_pkg::alu_inputs_t alu_in;
    logic [31:0]           result;
    core_pkg::wb_t         wb;

    ////////////////////
    // Fetch and sequencing
    pc_counter #(
        .RESET_VECTOR (RESET_VECTOR),
        .IMEM_ADDR_W  (IMEM_ADDR_W)
    ) pc_counter_block (
        .clk       (clk),
        .rst       (rst),
        .advance   (retire),
        .pc        (pc),
        .imem_addr (imem_addr)
    );

    issue_control issue_control_block (
        .clk     (clk),
        .rst     (rst),
        .illegal (dec.illegal),
        .imem_en (imem_en),
        .capture (capture),
        .exec_en (exec_en),
        .retire  (retire),
        .halted  (halted)
    );

    ////////////////////
    // Decode and operands
    decode decode_block (
        .clk       (clk),
        .rst       (rst),
        .capture   (capture),
        .imem_data (imem_data),
        .instr     (instr),
        .dec       (dec)
    );

    register_file register_file_block (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Immediate replaces rs2 for OP-IMM
    assign alu_in.alu_op = dec.alu_op;
    assign alu_in.a      = rs1_data;
    assign alu_in.b      = dec.use_imm ? dec.imm : rs2_data;

    ////////////////////
    // Execute and writeback
    alu_unit alu_unit_block (
        .clk     (clk),
        .rst     (rst),
        .exec_en (exec_en),
        .alu_in  (alu_in),
        .result  (result)
    );

    // Every legal instruction writes rd and the file drops x0
    assign wb.we    = retire;
    assign wb.rd    = dec.rd;
    assign wb.value = result;

    ////////////////////
    // Trace

    // One cycle behind the retire edge
    // pc still points at the retiring instruction during RETIRE
    always_ff @(posedge clk) begin
        if (rst) begin
            tr.retired <= 1'b0;
        end else begin
            tr.retired <= retire;
            if (retire) begin
                tr.pc    <= pc;
                tr.instr <= instr;
                tr.rd    <= dec.rd;
                tr.value <= result;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// Free-running testbench clock; 8 ns period, starts low at time zero, never stops on its own
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // Half of the 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* testbench/core_props.sv */
// Sequencing and trace properties bound into tiny_core; all checks are idle while rst is high
`default_nettype none
`timescale 1ns/1ps

module core_props (
    input logic clk,
    input logic rst,
    input logic imem_en,
    input logic capture,
    input logic retire,
    input logic halted,
    input logic tr_retired
);

    // Failed property count
    int assert_failures = 0;

    ////////////////////
    // Phase order

    // Memory word is captured the cycle after the request
    fetch_then_capture: assert property (@(posedge clk) disable iff (rst) imem_en |=> capture)
        else begin
            $error("capture did not follow the fetch strobe");
            assert_failures++;
        end

    // A halted core retires nothing
    no_retire_halted: assert property (@(posedge clk) disable iff (rst) retire |-> !halted)
        else begin
            $error("retire strobe while halted");
            assert_failures++;
        end

    // Only reset leaves HALT
    halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            $error("halted dropped without reset");
            assert_failures++;
        end

    ////////////////////
    // Trace

    // One pulse per retired instruction
    retired_pulse: assert property (@(posedge clk) disable iff (rst) tr_retired |=> !tr_retired)
        else begin
            $error("trace retired strobe longer than one cycle");
            assert_failures++;
        end

endmodule

bind tiny_core core_props core_props_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_en    (imem_en),
    .capture    (capture),
    .retire     (retire),
    .halted     (halted),
    .tr_retired (tr.retired)
);

`default_nettype wire

/* testbench/core_tb.sv */
// Core testbench; run from the project root so testbench/core_golden.txt is found, memory is 256 words
`default_nettype none
`timescale 1ns/1ps

module core_tb;

    localparam int IMEM_ADDR_W = 8;
    // Cycle limit for every wait loop
    localparam int WAIT_LIMIT  = 50;

    logic                   clk;
    logic                   rst;
    logic                   imem_en;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    logic [31:0]            imem_data;
    core_pkg::trace_t       tr;
    logic                   halted;

    // Instruction memory and expected retirement records
    logic [31:0] imem [2**IMEM_ADDR_W];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_value [$];
    logic [31:0] halt_pc;

    tb_clock clock_gen (
        .clk (clk)
    );

    tiny_core #(
        .RESET_VECTOR (32'h0000_0000),
        .IMEM_ADDR_W  (IMEM_ADDR_W)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .imem_en   (imem_en),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .tr        (tr),
        .halted    (halted)
    );

    ////////////////////
    // Memory model

    // Fixed one-cycle read latency
    always @(posedge clk) begin
        if (imem_en) begin
            imem_data <= imem[imem_addr];
        end
    end

    ////////////////////
    // Helpers
    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, expected, actual);
            abort_run();
        end
    endtask

    // Tag I program word, E expected retirement, H halt pc, # comment line
    task automatic load_golden();
        int          fd;
        int          code;
        byte         tag;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("testbench/core_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file testbench/core_golden.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %h", a, b);
                imem[a] = b;
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h %h %h", a, b, c);
                exp_pc.push_back(a);
                exp_rd.push_back(b[4:0]);
                exp_value.push_back(c);
            end else if (tag == "H") begin
                code = $fscanf(fd, "%h", halt_pc);
            end else begin
                $display("unknown record tag in the golden file");
                abort_run();
            end
        end
        $fclose(fd);
    endtask

    // Returns the number of cycles spent waiting
    task automatic wait_retire(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timed out waiting for an instruction to retire");
                abort_run();
            end
        end while (!tr.retired);
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (tr.retired) begin
                $display("an instruction retired after the last expected record");
                abort_run();
            end
            if (cycles > WAIT_LIMIT) begin
                $display("timed out waiting for the core to halt");
                abort_run();
            end
        end
    endtask

    ////////////////////
    // Stimulus and checks
    initial begin
        int gap;
        rst       = 1'b1;
        imem_data = 32'd0;
        // Unwritten words hold an illegal opcode tagged with their address
        for (int i = 0; i < 2**IMEM_ADDR_W; i++) begin
            imem[i] = 32'hbad0_007f | (i << 7);
        end
        load_golden();

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // First cycle out of reset fetches the reset vector
        @(negedge clk);
        check_value(1, imem_en, "fetch strobe after reset");
        check_value(0, imem_addr, "first fetch address");
        check_value(0, halted, "halted after reset");

        foreach (exp_pc[k]) begin
            wait_retire(gap);
            if (k > 0) begin
                check_value(4, gap, "cycles between retirements");
            end
            check_value(exp_pc[k], tr.pc, "trace pc");
            check_value(exp_rd[k], tr.rd, "trace rd");
            check_value(exp_value[k], tr.value, "trace value");
            check_value(imem[tr.pc[IMEM_ADDR_W+1:2]], tr.instr, "trace instruction word");
        end

        // Illegal word parks the core at its own address
        wait_halt();
        check_value(halt_pc - 32'd4, tr.pc, "last retired pc before the halt");
        check_value(halt_pc[IMEM_ADDR_W+1:2], imem_addr, "pc held at the illegal word");
        repeat (8) begin
            @(negedge clk);
            check_value(1, halted, "halted stays high");
            check_value(0, tr.retired, "no retirement while halted");
        end
        check_value(0, DUT.core_props_inst.assert_failures, "failed properties");

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/core_pkg.sv
design/pc_counter.sv
design/issue_control.sv
design/decode.sv
design/register_file.sv
design/alu_unit.sv
design/tiny_core.sv
testbench/tb_clock.sv
testbench/core_props.sv
testbench/core_tb.sv

/* testbench/core_golden.txt */
# I word_addr instr ; E pc rd value ; H halt_pc  (all fields hex)
# Registers start at zero, x1 = -5 and x2 = 12 feed the later operations
I 00 ffb00093
I 01 00c00113
I 02 002081b3
I 03 40208233
I 04 0020f2b3
I 05 0020e333
I 06 0020c3b3
I 07 00209433
I 08 0020d4b3
I 09 4020d533
I 0a 0020a5b3
I 0b 0020b633
I 0c fff14693
I 0d ffc0a713
I 0e 4020d813
I 0f 06408013
I 10 002009b3
I 11 0000006f
E 00 01 fffffffb
E 04 02 0000000c
E 08 03 00000007
E 0c 04 ffffffef
E 10 05 00000008
E 14 06 ffffffff
E 18 07 fffffff7
E 1c 08 ffffb000
E 20 09 000fffff
E 24 0a ffffffff
E 28 0b 00000001
E 2c 0c 00000000
E 30 0d fffffff3
E 34 0e 00000001
E 38 10 fffffffe
E 3c 00 0000005f
E 40 13 0000000c
H 44
